// File: compile.f
+incdir+sim
design/fmaPkg.sv
design/prefixAdder.sv
design/csaTree.sv
design/smMultiplier.sv
design/smAdder.sv
design/creditCounter.sv
design/fmaTop.sv
sim/fmaTb.sv

// File: Makefile
# Verilator build and run of the FMA testbench

VERILATOR ?= verilator
TOP ?= fmaTb
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) || (echo "FAIL: see $(LOG)" && exit 1)
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/fmaCheck.svh
`ifndef FMA_CHECK_SVH
`define FMA_CHECK_SVH

// x^16 + x^14 + x^13 + x^11 + 1, shifting toward the top bit
function automatic logic [15:0] lfsrStep(input logic [15:0] state);
	logic feedback;
	feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
	return {state[14:0], feedback};
endfunction

// Sign is the XOR of the operand signs even for a zero magnitude
function automatic logic [RES_WIDTH-1:0] smProduct(input logic [OP_WIDTH-1:0] a,
		input logic [OP_WIDTH-1:0] b);
	logic [PROD_MAG_WIDTH-1:0] mag;
	mag = PROD_MAG_WIDTH'(a[MAG_WIDTH-1:0]) * PROD_MAG_WIDTH'(b[MAG_WIDTH-1:0]);
	return {a[OP_WIDTH-1] ^ b[OP_WIDTH-1], mag};
endfunction

function automatic logic [RES_WIDTH-1:0] smSum(input logic [RES_WIDTH-1:0] x,
		input logic [RES_WIDTH-1:0] y);
	logic [PROD_MAG_WIDTH-1:0] posMag;
	logic [PROD_MAG_WIDTH-1:0] negMag;
	logic [RES_WIDTH-1:0] sum;
	posMag = x[RES_WIDTH-1] ? y[PROD_MAG_WIDTH-1:0] : x[PROD_MAG_WIDTH-1:0];
	negMag = x[RES_WIDTH-1] ? x[PROD_MAG_WIDTH-1:0] : y[PROD_MAG_WIDTH-1:0];
	if (x[RES_WIDTH-1] == y[RES_WIDTH-1]) begin
		// Carry out of bit 29 is lost
		sum = {x[RES_WIDTH-1], x[PROD_MAG_WIDTH-1:0] + y[PROD_MAG_WIDTH-1:0]};
	end else if (posMag >= negMag) begin
		sum = {1'b0, posMag - negMag};
	end else begin
		sum = {1'b1, negMag - posMag};
	end
	return sum;
endfunction

`endif

// File: sim/fmaTb.sv
`timescale 1ns/1ps
`default_nettype none

module fmaTb import fmaPkg::*; ();

	localparam int RESET_CYCLES = 8;
	localparam logic [15:0] LFSR_SEED = 16'd13;
	localparam int DIRECTED_OPS = 4;
	localparam int ZERO_OPS = 32;
	localparam int SAME_OPS = 32;
	localparam int DIFF_OPS = 32;
	localparam int CREDIT_OPS = MAX_CREDITS + 3;
	localparam int CREDIT_WAIT = 6;
	localparam int TOTAL_OPS = DIRECTED_OPS + ZERO_OPS + SAME_OPS + DIFF_OPS + CREDIT_OPS;
	// Cycles per operation for drive, pipeline and credit return
	localparam int OP_CYCLES = PIPE_LATENCY + 3;
	localparam int CYCLE_LIMIT = 2 * (TOTAL_OPS * OP_CYCLES + CREDIT_WAIT) + RESET_CYCLES;

	logic clk;
	logic rstN_i;
	logic inValid_i;
	logic [OP_WIDTH-1:0] a_i;
	logic [OP_WIDTH-1:0] b_i;
	logic [RES_WIDTH-1:0] c_i;
	logic creditReturn_i;
	logic inReady_o;
	logic resultValid_o;
	logic [RES_WIDTH-1:0] result_o;

	logic [15:0] lfsr = LFSR_SEED;
	logic [RES_WIDTH-1:0] expQ [$];
	int dueQ [$];
	int cycle = 0;
	int acceptCount = 0;
	int resultCount = 0;
	int pendingReturns = 0;
	bit autoReturn = 1'b1;

	`include "fmaCheck.svh"

	fmaTop UUT (
		.clk(clk),
		.rstN_i(rstN_i),
		.inValid_i(inValid_i),
		.a_i(a_i),
		.b_i(b_i),
		.c_i(c_i),
		.creditReturn_i(creditReturn_i),
		.inReady_o(inReady_o),
		.resultValid_o(resultValid_o),
		.result_o(result_o)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic stopRun(input string what);
		$display("%s", what);
		$display("tests failed");
		$fatal(1);
	endtask

	function automatic logic [31:0] randBits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsr = lfsrStep(lfsr);
			value = {value[30:0], lfsr[0]};
		end
		return value;
	endfunction

	// Consumer drains one result per pending credit
	task automatic nextCycle();
		@(negedge clk);
		if (autoReturn && pendingReturns > 0) begin
			creditReturn_i = 1'b1;
			pendingReturns--;
		end else begin
			creditReturn_i = 1'b0;
		end
	endtask

	task automatic sendOp(input logic [OP_WIDTH-1:0] a, input logic [OP_WIDTH-1:0] b,
			input logic [RES_WIDTH-1:0] c);
		inValid_i = 1'b1;
		a_i = a;
		b_i = b;
		c_i = c;
		while (!inReady_o) begin
			nextCycle();
		end
		nextCycle();
		inValid_i = 1'b0;
	endtask

	task automatic drain();
		while (expQ.size() > 0 || pendingReturns > 0) begin
			nextCycle();
		end
		// Last return lands on the next edge
		nextCycle();
	endtask

	// Scoreboard and latency check with expected values queued at acceptance
	always @(posedge clk) begin
		cycle++;
		if (cycle > CYCLE_LIMIT) begin
			stopRun($sformatf("Timeout: the run did not finish within %0d cycles",
				CYCLE_LIMIT));
		end else if (rstN_i) begin
			if (inValid_i && inReady_o) begin
				expQ.push_back(smSum(smProduct(a_i, b_i), c_i));
				dueQ.push_back(cycle + PIPE_LATENCY);
				acceptCount++;
			end
			if (resultValid_o) begin
				assert (expQ.size() > 0)
					else stopRun("A result came out with no operation in flight");
				assert (dueQ[0] == cycle)
					else stopRun($sformatf("Error at %0t: result at cycle %0d, due at cycle %0d",
						$time, cycle, dueQ[0]));
				assert (result_o == expQ[0])
					else stopRun($sformatf("Error at %0t: result %h, expected %h",
						$time, result_o, expQ[0]));
				void'(expQ.pop_front());
				void'(dueQ.pop_front());
				resultCount++;
				pendingReturns++;
			end else if (dueQ.size() > 0) begin
				assert (dueQ[0] != cycle)
					else stopRun($sformatf("Error at %0t: no result at cycle %0d", $time, cycle));
			end
		end
	end

	initial begin
		logic [OP_WIDTH-1:0] opA;
		logic [OP_WIDTH-1:0] opB;
		logic [PROD_MAG_WIDTH-1:0] addMag;
		logic [RES_WIDTH-1:0] prod;
		int heldCount;
		rstN_i = 1'b0;
		inValid_i = 1'b0;
		a_i = '0;
		b_i = '0;
		c_i = '0;
		creditReturn_i = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rstN_i = 1'b1;
		assert (inReady_o && !resultValid_o)
			else stopRun($sformatf("Error at %0t: inReady_o %b, resultValid_o %b after reset",
				$time, inReady_o, resultValid_o));

		// Zero products against both zero addends and a wrap past 2^30
		sendOp(16'h0000, 16'h8005, {1'b0, 30'h0});
		sendOp(16'h8000, 16'h0003, {1'b1, 30'h0});
		sendOp(16'h0000, 16'h0007, {1'b1, 30'h0});
		sendOp(16'h7fff, 16'h7fff, {1'b0, 30'h3fffffff});

		for (int i = 0; i < ZERO_OPS; i++) begin
			opA = OP_WIDTH'(randBits(OP_WIDTH));
			opB = OP_WIDTH'(randBits(OP_WIDTH));
			if (i % 8 == 0) begin
				opA[MAG_WIDTH-1:0] = '0;
			end
			sendOp(opA, opB, {1'(randBits(1)), {PROD_MAG_WIDTH{1'b0}}});
		end

		for (int i = 0; i < SAME_OPS; i++) begin
			opA = OP_WIDTH'(randBits(OP_WIDTH));
			opB = OP_WIDTH'(randBits(OP_WIDTH));
			addMag = PROD_MAG_WIDTH'(randBits(PROD_MAG_WIDTH));
			if (i % 2 == 0) begin
				// Product >= 2^28 and addend >= 3 * 2^28 always wrap
				opA[MAG_WIDTH-1] = 1'b1;
				opB[MAG_WIDTH-1] = 1'b1;
				addMag[PROD_MAG_WIDTH-1 -: 2] = 2'b11;
			end
			sendOp(opA, opB, {opA[OP_WIDTH-1] ^ opB[OP_WIDTH-1], addMag});
		end

		for (int i = 0; i < DIFF_OPS; i++) begin
			opA = OP_WIDTH'(randBits(OP_WIDTH));
			opB = OP_WIDTH'(randBits(OP_WIDTH));
			prod = smProduct(opA, opB);
			if (i % 4 == 0) begin
				addMag = prod[PROD_MAG_WIDTH-1:0];
			end else if (i % 4 == 1) begin
				addMag = PROD_MAG_WIDTH'(randBits(20));
			end else begin
				addMag = PROD_MAG_WIDTH'(randBits(PROD_MAG_WIDTH));
			end
			sendOp(opA, opB, {~prod[RES_WIDTH-1], addMag});
		end
		drain();

		// Credit pool with the consumer holding its returns
		autoReturn = 1'b0;
		for (int i = 0; i < MAX_CREDITS; i++) begin
			sendOp(OP_WIDTH'(randBits(OP_WIDTH)), OP_WIDTH'(randBits(OP_WIDTH)),
				RES_WIDTH'(randBits(RES_WIDTH)));
		end
		assert (!inReady_o)
			else stopRun($sformatf("Error at %0t: inReady_o high with no credits left", $time));
		heldCount = acceptCount;
		inValid_i = 1'b1;
		a_i = OP_WIDTH'(randBits(OP_WIDTH));
		b_i = OP_WIDTH'(randBits(OP_WIDTH));
		c_i = RES_WIDTH'(randBits(RES_WIDTH));
		repeat (CREDIT_WAIT) begin
			nextCycle();
			assert (!inReady_o && acceptCount == heldCount)
				else stopRun("An operation was accepted without a credit");
		end
		creditReturn_i = 1'b1;
		pendingReturns--;
		nextCycle();
		nextCycle();
		assert (!inReady_o && acceptCount == heldCount + 1)
			else stopRun("One returned credit did not reopen exactly one acceptance");
		inValid_i = 1'b0;

		creditReturn_i = 1'b1;
		pendingReturns--;
		nextCycle();
		inValid_i = 1'b1;
		a_i = OP_WIDTH'(randBits(OP_WIDTH));
		b_i = OP_WIDTH'(randBits(OP_WIDTH));
		c_i = RES_WIDTH'(randBits(RES_WIDTH));
		creditReturn_i = 1'b1;
		pendingReturns--;
		nextCycle();
		inValid_i = 1'b0;
		assert (inReady_o && acceptCount == heldCount + 2)
			else stopRun("A return together with an acceptance changed the credit count");

		// The single credit left must close after one more acceptance
		sendOp(OP_WIDTH'(randBits(OP_WIDTH)), OP_WIDTH'(randBits(OP_WIDTH)),
			RES_WIDTH'(randBits(RES_WIDTH)));
		assert (!inReady_o && acceptCount == heldCount + 3)
			else stopRun("The credit count drifted when a return met an acceptance");
		autoReturn = 1'b1;
		drain();

		assert (acceptCount == TOTAL_OPS && resultCount == TOTAL_OPS)
			$display("all tests passed");
		else
			stopRun($sformatf("Error at %0t: %0d accepted and %0d results, planned %0d",
				$time, acceptCount, resultCount, TOTAL_OPS));
		$finish;
	end

endmodule

`default_nettype wire

// File: design/fmaTop.sv
`timescale 1ns/1ps
`default_nettype none

module fmaTop import fmaPkg::*; (
	input  logic                 clk,
	input  logic                 rstN_i,
	input  logic                 inValid_i,
	input  logic [OP_WIDTH-1:0]  a_i,
	input  logic [OP_WIDTH-1:0]  b_i,
	input  logic [RES_WIDTH-1:0] c_i,
	input  logic                 creditReturn_i,
	output logic                 inReady_o,
	output logic                 resultValid_o,
	output logic [RES_WIDTH-1:0] result_o
);

	logic take;
	logic prodValid;
	logic [RES_WIDTH-1:0] product;
	logic [RES_WIDTH-1:0] addend;

	creditCounter credit (
		.clk(clk),
		.rstN_i(rstN_i),
		.inValid_i(inValid_i),
		.creditReturn_i(creditReturn_i),
		.inReady_o(inReady_o),
		.take_o(take)
	);

	// Stage 1
	smMultiplier mulStage (
		.clk(clk),
		.rstN_i(rstN_i),
		.take_i(take),
		.a_i(a_i),
		.b_i(b_i),
		.c_i(c_i),
		.prodValid_o(prodValid),
		.product_o(product),
		.addend_o(addend)
	);

	// Stage 2
	smAdder addStage (
		.clk(clk),
		.rstN_i(rstN_i),
		.prodValid_i(prodValid),
		.product_i(product),
		.addend_i(addend),
		.resultValid_o(resultValid_o),
		.result_o(result_o)
	);

endmodule

`default_nettype wire

// File: design/creditCounter.sv
`timescale 1ns/1ps
`default_nettype none

module creditCounter import fmaPkg::*; (
	input  logic clk,
	input  logic rstN_i,
	input  logic inValid_i,
	input  logic creditReturn_i,
	output logic inReady_o,
	output logic take_o
);

	logic [CREDIT_WIDTH-1:0] credits;
	logic full;

	assign full = credits == CREDIT_WIDTH'(MAX_CREDITS);
	assign inReady_o = credits != '0;

	// Sole acceptance point for the pipeline
	assign take_o = inValid_i && inReady_o;

	always_ff @(posedge clk) begin
		if (!rstN_i) begin
			credits <= CREDIT_WIDTH'(MAX_CREDITS);
		end else begin
			case ({take_o, creditReturn_i})
				2'b10: credits <= credits - 1'b1;
				2'b01: begin
					// Spurious return at full pool
					if (!full) begin
						credits <= credits + 1'b1;
					end
				end
				default: credits <= credits;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/smAdder.sv
`timescale 1ns/1ps
`default_nettype none

module smAdder import fmaPkg::*; (
	input  logic                 clk,
	input  logic                 rstN_i,
	input  logic                 prodValid_i,
	input  logic [RES_WIDTH-1:0] product_i,
	input  logic [RES_WIDTH-1:0] addend_i,
	output logic                 resultValid_o,
	output logic [RES_WIDTH-1:0] result_o
);

	logic prodSign;
	logic addSign;
	logic sameSign;
	logic [PROD_MAG_WIDTH-1:0] opA;
	logic [PROD_MAG_WIDTH-1:0] opB;
	logic [PROD_MAG_WIDTH-1:0] rawSum;
	logic [PROD_MAG_WIDTH-1:0] negSum;
	logic rawCarry;
	logic resSign;
	logic [PROD_MAG_WIDTH-1:0] resMag;

	assign prodSign = product_i[RES_WIDTH-1];
	assign addSign = addend_i[RES_WIDTH-1];
	assign sameSign = prodSign == addSign;

	// Negative side goes in as ones complement, carry in completes it
	assign opA = (!sameSign && prodSign) ? ~product_i[PROD_MAG_WIDTH-1:0]
		: product_i[PROD_MAG_WIDTH-1:0];
	assign opB = (!sameSign && addSign) ? ~addend_i[PROD_MAG_WIDTH-1:0]
		: addend_i[PROD_MAG_WIDTH-1:0];

	prefixAdder #(
		.WIDTH(PROD_MAG_WIDTH)
	) magAdder (
		.a_i(opA),
		.b_i(opB),
		.carry_i(!sameSign),
		.sum_o(rawSum),
		.carry_o(rawCarry)
	);

	// Twos complement of the difference
	prefixAdder #(
		.WIDTH(PROD_MAG_WIDTH)
	) negAdder (
		.a_i(~rawSum),
		.b_i('0),
		.carry_i(1'b1),
		.sum_o(negSum),
		.carry_o()
	);

	// With differing signs the carry means positive side >= negative side
	always_comb begin
		if (sameSign) begin
			resSign = prodSign;
			resMag = rawSum;
		end else if (rawCarry) begin
			resSign = 1'b0;
			resMag = rawSum;
		end else begin
			resSign = 1'b1;
			resMag = negSum;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN_i) begin
			resultValid_o <= 1'b0;
		end else begin
			resultValid_o <= prodValid_i;
		end
	end

	always_ff @(posedge clk) begin
		if (prodValid_i) begin
			result_o <= {resSign, resMag};
		end
	end

endmodule

`default_nettype wire

// File: design/smMultiplier.sv
`timescale 1ns/1ps
`default_nettype none

module smMultiplier import fmaPkg::*; (
	input  logic                 clk,
	input  logic                 rstN_i,
	input  logic                 take_i,
	input  logic [OP_WIDTH-1:0]  a_i,
	input  logic [OP_WIDTH-1:0]  b_i,
	input  logic [RES_WIDTH-1:0] c_i,
	output logic                 prodValid_o,
	output logic [RES_WIDTH-1:0] product_o,
	output logic [RES_WIDTH-1:0] addend_o
);

	logic [PROD_MAG_WIDTH-1:0] rowA;
	logic [PROD_MAG_WIDTH-1:0] rowB;
	logic [PROD_MAG_WIDTH-1:0] prodMag;
	logic prodSign;

	csaTree tree (
		.aMag_i(a_i[MAG_WIDTH-1:0]),
		.bMag_i(b_i[MAG_WIDTH-1:0]),
		.rowA_o(rowA),
		.rowB_o(rowB)
	);

	// Resolve the two carry-save rows
	prefixAdder #(
		.WIDTH(PROD_MAG_WIDTH)
	) rowAdder (
		.a_i(rowA),
		.b_i(rowB),
		.carry_i(1'b0),
		.sum_o(prodMag),
		.carry_o()
	);

	// Sign kept even for a zero magnitude
	assign prodSign = a_i[OP_WIDTH-1] ^ b_i[OP_WIDTH-1];

	always_ff @(posedge clk) begin
		if (!rstN_i) begin
			prodValid_o <= 1'b0;
		end else begin
			prodValid_o <= take_i;
		end
	end

	always_ff @(posedge clk) begin
		if (take_i) begin
			product_o <= {prodSign, prodMag};
			addend_o <= c_i;
		end
	end

endmodule

`default_nettype wire

// File: design/csaTree.sv
`timescale 1ns/1ps
`default_nettype none

module csaTree import fmaPkg::*; (
	input  logic [MAG_WIDTH-1:0]      aMag_i,
	input  logic [MAG_WIDTH-1:0]      bMag_i,
	output logic [PROD_MAG_WIDTH-1:0] rowA_o,
	output logic [PROD_MAG_WIDTH-1:0] rowB_o
);

	// Row count left after a number of 3:2 levels
	function automatic int rowsAfter(int level);
		int n;
		n = MAG_WIDTH;
		for (int l = 0; l < level; l++) begin
			n = 2 * (n / 3) + n % 3;
		end
		return n;
	endfunction

	function automatic int levelCount();
		int n;
		int l;
		n = MAG_WIDTH;
		l = 0;
		while (n > 2) begin
			n = 2 * (n / 3) + n % 3;
			l++;
		end
		return l;
	endfunction

	// 15 -> 10 -> 7 -> 5 -> 4 -> 3 -> 2
	localparam int LEVELS = levelCount();

	wire [PROD_MAG_WIDTH-1:0] rows [0:LEVELS][0:MAG_WIDTH-1];

	// Partial products, row j weighted by 2^j
	for (genvar j = 0; j < MAG_WIDTH; j++) begin : gPp
		assign rows[0][j] = {{(PROD_MAG_WIDTH - MAG_WIDTH){1'b0}},
			aMag_i & {MAG_WIDTH{bMag_i[j]}}} << j;
	end

	for (genvar l = 0; l < LEVELS; l++) begin : gLevel
		localparam int N = rowsAfter(l);
		localparam int GROUPS = N / 3;
		localparam int NEXT = 2 * GROUPS + N % 3;

		// Each group of three rows becomes a sum row and a carry row
		for (genvar g = 0; g < GROUPS; g++) begin : gCsa
			wire [PROD_MAG_WIDTH-1:0] x;
			wire [PROD_MAG_WIDTH-1:0] y;
			wire [PROD_MAG_WIDTH-1:0] z;
			assign x = rows[l][3*g];
			assign y = rows[l][3*g+1];
			assign z = rows[l][3*g+2];
			assign rows[l+1][2*g] = x ^ y ^ z;
			assign rows[l+1][2*g+1] = ((x & y) | (x & z) | (y & z)) << 1;
		end

		// Leftover rows pass to the next level
		for (genvar r = 0; r < N % 3; r++) begin : gPass
			assign rows[l+1][2*GROUPS+r] = rows[l][3*GROUPS+r];
		end

		for (genvar r = NEXT; r < MAG_WIDTH; r++) begin : gIdle
			assign rows[l+1][r] = '0;
		end
	end

	// Product fits in 30 bits so dropped carries out of the top are zero
	assign rowA_o = rows[LEVELS][0];
	assign rowB_o = rows[LEVELS][1];

endmodule

`default_nettype wire

// File: design/prefixAdder.sv
`timescale 1ns/1ps
`default_nettype none

module prefixAdder #(
	parameter int WIDTH = 30
) (
	input  logic [WIDTH-1:0] a_i,
	input  logic [WIDTH-1:0] b_i,
	input  logic             carry_i,
	output logic [WIDTH-1:0] sum_o,
	output logic             carry_o
);

	localparam int LEVELS = $clog2(WIDTH);
	localparam int STAGES = 2 * LEVELS;
	localparam int LAST = STAGES - 1;

	// Stage 0 is bitwise, then up-sweep, then down-sweep
	wire [WIDTH-1:0] gen [0:STAGES-1];
	wire [WIDTH-1:0] prop [0:STAGES-1];
	wire [WIDTH:0] carry;

	for (genvar i = 0; i < WIDTH; i++) begin : gBit
		assign gen[0][i] = a_i[i] & b_i[i];
		assign prop[0][i] = a_i[i] ^ b_i[i];
	end

	// Binary tree toward the top bit of each block
	for (genvar s = 1; s <= LEVELS; s++) begin : gUp
		localparam int D = 1 << (s - 1);
		for (genvar i = 0; i < WIDTH; i++) begin : gNode
			if ((i + 1) % (2 * D) == 0) begin : gMerge
				assign gen[s][i] = gen[s-1][i] | (prop[s-1][i] & gen[s-1][i-D]);
				assign prop[s][i] = prop[s-1][i] & prop[s-1][i-D];
			end else begin : gKeep
				assign gen[s][i] = gen[s-1][i];
				assign prop[s][i] = prop[s-1][i];
			end
		end
	end

	// Fill in the remaining prefixes from already complete ones
	for (genvar t = 1; t < LEVELS; t++) begin : gDown
		localparam int S = LEVELS + t;
		localparam int D = 1 << (LEVELS - 1 - t);
		for (genvar i = 0; i < WIDTH; i++) begin : gNode
			if ((i + 1) % (2 * D) == D && i >= 2 * D) begin : gMerge
				assign gen[S][i] = gen[S-1][i] | (prop[S-1][i] & gen[S-1][i-D]);
				assign prop[S][i] = prop[S-1][i] & prop[S-1][i-D];
			end else begin : gKeep
				assign gen[S][i] = gen[S-1][i];
				assign prop[S][i] = prop[S-1][i];
			end
		end
	end

	// Every node now spans bit 0 up to itself
	assign carry[0] = carry_i;
	for (genvar i = 0; i < WIDTH; i++) begin : gCarry
		assign carry[i+1] = gen[LAST][i] | (prop[LAST][i] & carry_i);
	end

	assign sum_o = prop[0] ^ carry[WIDTH-1:0];
	assign carry_o = carry[WIDTH];

endmodule

`default_nettype wire

// File: design/fmaPkg.sv
`default_nettype none

package fmaPkg;

	// Operand format is one sign bit over the magnitude
	localparam int OP_WIDTH = 16;
	localparam int MAG_WIDTH = OP_WIDTH - 1;

	// Product, addend and result share one sign-magnitude format
	localparam int PROD_MAG_WIDTH = 2 * MAG_WIDTH;
	localparam int RES_WIDTH = PROD_MAG_WIDTH + 1;

	// Result slots held by the consumer
	localparam int MAX_CREDITS = 4;
	localparam int CREDIT_WIDTH = $clog2(MAX_CREDITS + 1);

	// Multiply stage plus add stage
	localparam int PIPE_LATENCY = 2;

endpackage

`default_nettype wire
